// File: src/lcx_pkg.sv
package lcx_pkg;

// Fuse lifecycle encoding, sequential so test ranges can be matched with inside
typedef enum logic [4:0] {
    LC_RAW = 5'd0,          // Blank fuses read all zeros
    LC_TEST_UNLOCKED0,
    LC_TEST_UNLOCKED1,
    LC_TEST_UNLOCKED2,
    LC_TEST_UNLOCKED3,
    LC_TEST_UNLOCKED4,
    LC_TEST_UNLOCKED5,
    LC_TEST_UNLOCKED6,
    LC_TEST_UNLOCKED7,
    LC_TEST_LOCKED0,
    LC_TEST_LOCKED1,
    LC_TEST_LOCKED2,
    LC_TEST_LOCKED3,
    LC_TEST_LOCKED4,
    LC_TEST_LOCKED5,
    LC_TEST_LOCKED6,
    LC_DEV,
    LC_PROD,
    LC_PROD_END,
    LC_RMA,
    LC_SCRAP
} lc_state_e;

// Multibit enable, anything other than ON is treated as off
typedef enum logic [3:0] {
    LC_TX_ON  = 4'b0101,
    LC_TX_OFF = 4'b1010
} lc_tx_e;

typedef enum logic [2:0] {
    TR_RESET,
    TR_IDLE,
    TR_NON_DEBUG,
    TR_UNPROV_DEBUG,
    TR_MANUF_NON_DEBUG,
    TR_MANUF_DEBUG,
    TR_PROD_NON_DEBUG,
    TR_PROD_DEBUG
} trans_state_e;

typedef enum logic [1:0] {
    DEVICE_UNPROVISIONED,
    DEVICE_MANUFACTURING,
    DEVICE_PRODUCTION
} device_lifecycle_e;

typedef struct packed {
    device_lifecycle_e device_lifecycle;
    logic              debug_locked;
} security_state_t;

typedef struct packed {
    logic      valid;
    lc_state_e state;
} otp_lc_data_t;

typedef struct packed {
    logic      req;
    lc_state_e state;       // Live LC state carried with the request
} lc_prog_req_t;

typedef struct packed {
    logic [63:0] unlock_level;
    logic [63:0] dft_mask;
    logic [63:0] dbg_unlock_mask;
    logic [63:0] cltap_mask;
    logic [31:0] zeroize_mask;
} lcx_cfg_t;

typedef struct packed {
    security_state_t security_state;
    logic            soc_dft_en;
    logic            soc_hw_debug_en;
    logic            zeroize_cmd;
} lcx_status_t;

typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
} wb_req_t;

typedef struct packed {
    logic        ack;
    logic [31:0] dat;
} wb_rsp_t;

// Locked production state used out of reset and on escalation
localparam security_state_t SEC_STATE_DEFAULT = '{
    device_lifecycle: DEVICE_PRODUCTION,
    debug_locked:     1'b1
};

// Register word indices (byte address bits 7:2)
localparam logic [5:0] REG_UNLOCK_LO = 6'd0;
localparam logic [5:0] REG_UNLOCK_HI = 6'd1;
localparam logic [5:0] REG_DFT_LO    = 6'd2;
localparam logic [5:0] REG_DFT_HI    = 6'd3;
localparam logic [5:0] REG_DBG_LO    = 6'd4;
localparam logic [5:0] REG_DBG_HI    = 6'd5;
localparam logic [5:0] REG_CLTAP_LO  = 6'd6;
localparam logic [5:0] REG_CLTAP_HI  = 6'd7;
localparam logic [5:0] REG_ZEROIZE   = 6'd8;
localparam logic [5:0] REG_STATUS    = 6'd9;
localparam int unsigned LCX_CFG_WORDS = 9;  // Writable words below the status word

endpackage

// File: src/lcx_wb_regs.sv
`timescale 1ns/1ps

module lcx_wb_regs
    import lcx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_req_t     wb_i,
    output wb_rsp_t     wb_o,
    input  lcx_status_t status_i,
    output lcx_cfg_t    cfg_o
);

logic [LCX_CFG_WORDS-1:0][31:0] cfg_q;
logic                           ack_q;
logic [31:0]                    rdata_q;
logic [31:0]                    rdata_d;
logic [5:0]                     word_idx;
logic                           access;
logic                           cfg_hit;

assign word_idx = wb_i.adr[7:2];    // Byte offset bits are ignored
assign access   = wb_i.cyc && wb_i.stb && !ack_q;
assign cfg_hit  = (word_idx < 6'(LCX_CFG_WORDS));

// Read mux, sampled on the access edge
always_comb begin
    rdata_d = 32'h0;
    if (cfg_hit) begin
        rdata_d = cfg_q[word_idx];
    end else if (word_idx == REG_STATUS) begin
        rdata_d = {{(32 - $bits(lcx_status_t)){1'b0}}, status_i};
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ack_q   <= 1'b0;
        rdata_q <= 32'h0;
        cfg_q   <= '0;
    end else begin
        ack_q <= access;    // One cycle pulse, then ack_q blocks a repeat
        if (access) begin
            rdata_q <= rdata_d;
            if (wb_i.we && cfg_hit) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_i.sel[b]) begin
                        cfg_q[word_idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end
end

assign wb_o.ack = ack_q;
assign wb_o.dat = rdata_q;

// 64-bit values are split low word first
assign cfg_o.unlock_level    = {cfg_q[REG_UNLOCK_HI], cfg_q[REG_UNLOCK_LO]};
assign cfg_o.dft_mask        = {cfg_q[REG_DFT_HI], cfg_q[REG_DFT_LO]};
assign cfg_o.dbg_unlock_mask = {cfg_q[REG_DBG_HI], cfg_q[REG_DBG_LO]};
assign cfg_o.cltap_mask      = {cfg_q[REG_CLTAP_HI], cfg_q[REG_CLTAP_LO]};
assign cfg_o.zeroize_mask    = cfg_q[REG_ZEROIZE];

// Ack must answer a request that was present on the previous edge
a_ack_follows_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_o.ack |-> $past(wb_i.cyc && wb_i.stb)
) else $error("Wishbone ack without a preceding cycle");

endmodule

// File: src/lcx_state_trans.sv
`timescale 1ns/1ps

module lcx_state_trans
    import lcx_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  otp_lc_data_t    otp_data_i,
    input  lc_prog_req_t    lc_prog_req_i,
    input  lc_tx_e          lc_dft_en_i,
    input  lc_tx_e          lc_hw_debug_en_i,
    input  logic            dbg_manuf_enable_i,
    input  logic            state_error_i,
    input  lcx_cfg_t        cfg_i,
    output security_state_t security_state_o,
    output logic            soc_dft_en_o,
    output logic            soc_hw_debug_en_o
);

trans_state_e    state_q;
trans_state_e    state_d;
security_state_t sec_state_d;
lc_state_e       fuse_state_q;
logic            otp_valid;
logic            escalate;
logic            prod_unlock;
logic            dft_unlock;
logic            cltap_unlock;

assign otp_valid    = otp_data_i.valid;
// SCRAP request from the LC side or a fatal error from outside
assign escalate     = (lc_prog_req_i.req && lc_prog_req_i.state == LC_SCRAP) || state_error_i;
assign prod_unlock  = |(cfg_i.unlock_level & cfg_i.dbg_unlock_mask);
assign dft_unlock   = |(cfg_i.unlock_level & cfg_i.dft_mask);
assign cltap_unlock = |(cfg_i.unlock_level & cfg_i.cltap_mask);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state_q           <= TR_RESET;
        security_state_o  <= SEC_STATE_DEFAULT;
        fuse_state_q      <= LC_RAW;
        soc_dft_en_o      <= 1'b0;
        soc_hw_debug_en_o <= 1'b0;
    end else if (otp_valid) begin
        state_q          <= state_d;
        security_state_o <= sec_state_d;
        if (state_q == TR_RESET) begin
            fuse_state_q <= otp_data_i.state;   // Fuses are static once valid
        end
        soc_dft_en_o      <= (lc_dft_en_i == LC_TX_ON) || dft_unlock;
        soc_hw_debug_en_o <= (lc_hw_debug_en_i == LC_TX_ON) || cltap_unlock;
    end else begin
        // Fuse data not valid, hold everything in the locked default
        state_q           <= TR_RESET;
        security_state_o  <= SEC_STATE_DEFAULT;
        fuse_state_q      <= LC_RAW;
        soc_dft_en_o      <= 1'b0;
        soc_hw_debug_en_o <= 1'b0;
    end
end

always_comb begin
    state_d = state_q;
    case (state_q)
        TR_RESET: state_d = TR_IDLE;
        TR_IDLE: begin
            if (escalate || fuse_state_q == LC_SCRAP) begin
                state_d = TR_NON_DEBUG;
            end else if (fuse_state_q == LC_RAW ||
                         fuse_state_q inside {[LC_TEST_LOCKED0:LC_TEST_LOCKED6]}) begin
                state_d = TR_NON_DEBUG;
            end else if (fuse_state_q inside {[LC_TEST_UNLOCKED0:LC_TEST_UNLOCKED7]}) begin
                state_d = TR_UNPROV_DEBUG;
            end else if (fuse_state_q == LC_DEV) begin
                state_d = TR_MANUF_NON_DEBUG;
            end else if (fuse_state_q inside {LC_PROD, LC_PROD_END}) begin
                state_d = TR_PROD_NON_DEBUG;
            end else if (fuse_state_q == LC_RMA) begin
                state_d = TR_PROD_DEBUG;
            end else begin
                state_d = TR_NON_DEBUG;     // Undefined fuse codes stay locked
            end
        end
        TR_NON_DEBUG: state_d = TR_NON_DEBUG;  // Sticky until valid drops
        TR_MANUF_NON_DEBUG: begin
            if (escalate) begin
                state_d = TR_NON_DEBUG;
            end else if (dbg_manuf_enable_i) begin
                state_d = TR_MANUF_DEBUG;
            end
        end
        TR_PROD_NON_DEBUG: begin
            if (escalate) begin
                state_d = TR_NON_DEBUG;
            end else if (prod_unlock) begin
                state_d = TR_PROD_DEBUG;
            end
        end
        default: begin
            // Unlocked states only leave on escalation
            if (escalate) begin
                state_d = TR_NON_DEBUG;
            end
        end
    endcase
end

// Security state for the current state, escalation wins over everything
always_comb begin
    sec_state_d = SEC_STATE_DEFAULT;
    if (!escalate) begin
        case (state_q)
            TR_UNPROV_DEBUG:    sec_state_d = '{DEVICE_UNPROVISIONED, 1'b0};
            TR_MANUF_NON_DEBUG: sec_state_d = '{DEVICE_MANUFACTURING, 1'b1};
            TR_MANUF_DEBUG:     sec_state_d = '{DEVICE_MANUFACTURING, 1'b0};
            TR_PROD_DEBUG:      sec_state_d = '{DEVICE_PRODUCTION, 1'b0};
            default:            sec_state_d = SEC_STATE_DEFAULT;
        endcase
    end
end

a_non_debug_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == TR_NON_DEBUG && otp_valid) |=> state_q == TR_NON_DEBUG
) else $error("Translator left NON_DEBUG while fuse data valid");

a_invalid_locks: assert property (
    @(posedge clk) disable iff (!rst_n)
    !otp_valid |=> (security_state_o == SEC_STATE_DEFAULT &&
                    !soc_dft_en_o && !soc_hw_debug_en_o)
) else $error("Outputs not in locked default after valid low");

endmodule

// File: src/lcx_zeroize_timer.sv
`timescale 1ns/1ps

module lcx_zeroize_timer #(
    parameter int unsigned ZEROIZE_HOLD = 4    // Qualified cycles before the command
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        zeroize_req_i,
    input  logic [31:0] zeroize_mask_i,
    output logic        zeroize_cmd_o
);

localparam int unsigned CNT_W = $clog2(ZEROIZE_HOLD + 1);

logic [CNT_W-1:0] cnt_q;
logic             qualified;
logic             cnt_full;

// Request only counts when every mask bit is set
assign qualified = zeroize_req_i && (&zeroize_mask_i);
assign cnt_full  = (cnt_q == CNT_W'(ZEROIZE_HOLD));

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cnt_q <= '0;
    end else if (!qualified) begin
        cnt_q <= '0;                // Any gap restarts the hold
    end else if (!cnt_full) begin
        cnt_q <= cnt_q + 1'b1;      // Saturates at the hold count
    end
end

// Count only stays full while qualification holds
assign zeroize_cmd_o = cnt_full;

a_cmd_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    zeroize_cmd_o |-> $past(zeroize_req_i)
) else $error("Zeroization command without a held request");

endmodule

// File: src/lcx_top.sv
`timescale 1ns/1ps

module lcx_top
    import lcx_pkg::*;
#(
    parameter int unsigned ZEROIZE_HOLD = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_req_t         wb_i,
    output wb_rsp_t         wb_o,
    input  otp_lc_data_t    otp_data_i,
    input  lc_prog_req_t    lc_prog_req_i,
    input  lc_tx_e          lc_dft_en_i,
    input  lc_tx_e          lc_hw_debug_en_i,
    input  logic            dbg_manuf_enable_i,
    input  logic            state_error_i,
    input  logic            zeroize_req_i,
    output security_state_t security_state_o,
    output logic            soc_dft_en_o,
    output logic            soc_hw_debug_en_o,
    output logic            zeroize_cmd_o
);

lcx_cfg_t    cfg;
lcx_status_t status;

// Status word read back through the register block
assign status = '{
    security_state:  security_state_o,
    soc_dft_en:      soc_dft_en_o,
    soc_hw_debug_en: soc_hw_debug_en_o,
    zeroize_cmd:     zeroize_cmd_o
};

lcx_wb_regs lcx_wb_regs_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_i     (wb_i),
    .wb_o     (wb_o),
    .status_i (status),
    .cfg_o    (cfg)
);

lcx_state_trans lcx_state_trans_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .otp_data_i         (otp_data_i),
    .lc_prog_req_i      (lc_prog_req_i),
    .lc_dft_en_i        (lc_dft_en_i),
    .lc_hw_debug_en_i   (lc_hw_debug_en_i),
    .dbg_manuf_enable_i (dbg_manuf_enable_i),
    .state_error_i      (state_error_i),
    .cfg_i              (cfg),
    .security_state_o   (security_state_o),
    .soc_dft_en_o       (soc_dft_en_o),
    .soc_hw_debug_en_o  (soc_hw_debug_en_o)
);

lcx_zeroize_timer #(
    .ZEROIZE_HOLD (ZEROIZE_HOLD)
) lcx_zeroize_timer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .zeroize_req_i  (zeroize_req_i),
    .zeroize_mask_i (cfg.zeroize_mask),
    .zeroize_cmd_o  (zeroize_cmd_o)
);

endmodule

// File: tb/lcx_ref.svh
`ifndef LCX_REF_SVH
`define LCX_REF_SVH

// SCRAP request on the LC side or an external fatal error
function automatic logic ref_escalate(lc_prog_req_t req, logic err);
    return (req.req && req.state == LC_SCRAP) || err;
endfunction

// Next translator state, one edge at a time
function automatic trans_state_e ref_next(trans_state_e cur, lc_state_e fuse, logic esc,
                                          logic manuf_en, logic prod_unlock);
    trans_state_e nxt;
    nxt = cur;
    if (cur == TR_RESET) begin
        nxt = TR_IDLE;
    end else if (cur == TR_IDLE) begin
        nxt = TR_NON_DEBUG;             // RAW, TEST_LOCKED, SCRAP, undefined codes
        if (esc || fuse == LC_SCRAP) begin
            nxt = TR_NON_DEBUG;
        end else if (fuse >= LC_TEST_UNLOCKED0 && fuse <= LC_TEST_UNLOCKED7) begin
            nxt = TR_UNPROV_DEBUG;
        end else if (fuse == LC_DEV) begin
            nxt = TR_MANUF_NON_DEBUG;
        end else if (fuse == LC_PROD || fuse == LC_PROD_END) begin
            nxt = TR_PROD_NON_DEBUG;
        end else if (fuse == LC_RMA) begin
            nxt = TR_PROD_DEBUG;
        end
    end else if (esc) begin
        nxt = TR_NON_DEBUG;
    end else if (cur == TR_MANUF_NON_DEBUG && manuf_en) begin
        nxt = TR_MANUF_DEBUG;
    end else if (cur == TR_PROD_NON_DEBUG && prod_unlock) begin
        nxt = TR_PROD_DEBUG;
    end
    return nxt;
endfunction

// Security state shown for a settled translator state
function automatic security_state_t ref_security(trans_state_e st, logic esc);
    security_state_t s;
    s.device_lifecycle = DEVICE_PRODUCTION;
    s.debug_locked     = 1'b1;
    if (!esc && st == TR_UNPROV_DEBUG) begin
        s.device_lifecycle = DEVICE_UNPROVISIONED;
        s.debug_locked     = 1'b0;
    end else if (!esc && (st == TR_MANUF_NON_DEBUG || st == TR_MANUF_DEBUG)) begin
        s.device_lifecycle = DEVICE_MANUFACTURING;
        s.debug_locked     = (st == TR_MANUF_NON_DEBUG);
    end else if (!esc && st == TR_PROD_DEBUG) begin
        s.debug_locked = 1'b0;
    end
    return s;
endfunction

// OR of the lc_tx word and the masked unlock level
function automatic logic ref_enable(lc_tx_e tx, logic [63:0] level, logic [63:0] mask);
    return (tx == LC_TX_ON) || ((level & mask) != 64'h0);
endfunction

`endif

// File: tb/lcx_tb.sv
`timescale 1ns/1ps

module lcx_tb
    import lcx_pkg::*;
;

localparam int ZEROIZE_HOLD   = 4;
localparam int WB_LIMIT       = 20;
localparam int TIMEOUT_CYCLES = 4000;

logic            clk;
logic            rst_n;
wb_req_t         wb_req;
wb_rsp_t         wb_rsp;
otp_lc_data_t    otp_data;
lc_prog_req_t    prog_req;
lc_tx_e          dft_tx;
lc_tx_e          hw_tx;
logic            dbg_manuf;
logic            state_err;
logic            zeroize_req;
security_state_t sec_state;
logic            dft_en;
logic            hw_dbg_en;
logic            zeroize_cmd;

logic [31:0]     shadow [0:8];      // Expected register contents
trans_state_e    exp_state = TR_RESET;
logic            check_req = 1'b0;
int              cycle_cnt = 0;
lc_state_e       esc_fuses [0:3] = '{LC_TEST_UNLOCKED3, LC_DEV, LC_PROD, LC_RMA};

`include "lcx_ref.svh"

lcx_top #(
    .ZEROIZE_HOLD (ZEROIZE_HOLD)
) lcx_top_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_i               (wb_req),
    .wb_o               (wb_rsp),
    .otp_data_i         (otp_data),
    .lc_prog_req_i      (prog_req),
    .lc_dft_en_i        (dft_tx),
    .lc_hw_debug_en_i   (hw_tx),
    .dbg_manuf_enable_i (dbg_manuf),
    .state_error_i      (state_err),
    .zeroize_req_i      (zeroize_req),
    .security_state_o   (sec_state),
    .soc_dft_en_o       (dft_en),
    .soc_hw_debug_en_o  (hw_dbg_en),
    .zeroize_cmd_o      (zeroize_cmd)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end
end

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Simulation failed");
        $fatal(1, "mismatch on %s", name);
    end
endtask

// Expected status word from the reference model and the shadow registers
function automatic lcx_status_t expected_status();
    logic [63:0] level;
    lcx_status_t s;
    level             = {shadow[1], shadow[0]};
    s.security_state  = ref_security(exp_state, ref_escalate(prog_req, state_err));
    s.soc_dft_en      = otp_data.valid && ref_enable(dft_tx, level, {shadow[3], shadow[2]});
    s.soc_hw_debug_en = otp_data.valid && ref_enable(hw_tx, level, {shadow[7], shadow[6]});
    s.zeroize_cmd     = 1'b0;
    return s;
endfunction

// Single Wishbone classic access that returns 2 ns after a rising edge
task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                         input logic [3:0] sel, output logic [31:0] rdat);
    int waited;
    waited = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    wb_req.sel = sel;
    @(posedge clk);
    #1;
    while (!wb_rsp.ack) begin
        waited++;
        if (waited >= WB_LIMIT) begin
            $display("Wishbone access to 0x%0h was never acknowledged", adr);
            $display("Simulation failed");
            $fatal(1, "no ack");
        end
        @(posedge clk);
        #1;
    end
    rdat = wb_rsp.dat;      // Valid while ack is high
    #1;
    wb_req = '0;
    @(posedge clk);
    #1;
    check_value("wb_o.ack", 64'(wb_rsp.ack), 64'h0);   // Ack lasts a single cycle
    #1;
endtask

task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdat, input logic [3:0] sel);
    logic [31:0] rdat_ignored;
    int          idx;
    wb_access(1'b1, adr, wdat, sel, rdat_ignored);
    idx = int'(adr[7:2]);
    if (adr < 8'h24) begin
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                shadow[idx][8*b +: 8] = wdat[8*b +: 8];
            end
        end
    end
endtask

task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdat);
    wb_access(1'b0, adr, 32'h0, 4'h0, rdat);
endtask

task automatic clear_cfg();
    for (int i = 0; i < 9; i++) begin
        wb_write(8'(4 * i), 32'h0, 4'hF);
    end
endtask

// Advance the expected state and hand over to the compare process
task automatic settle_and_check();
    logic esc;
    logic prod_unlock;
    esc         = ref_escalate(prog_req, state_err);
    prod_unlock = ({shadow[1], shadow[0]} & {shadow[5], shadow[4]}) != 64'h0;
    if (!otp_data.valid) begin
        exp_state = TR_RESET;
    end else begin
        for (int step = 0; step < 4; step++) begin
            exp_state = ref_next(exp_state, otp_data.state, esc, dbg_manuf, prod_unlock);
        end
    end
    check_req = 1'b1;
    wait (!check_req);
    #1;
endtask

task automatic set_escalation(input int cause, input logic on);
    if (cause == 0) begin
        prog_req.req   = on;
        prog_req.state = on ? LC_SCRAP : LC_RAW;
    end else begin
        state_err = on;
    end
endtask

function automatic lc_tx_e pick_tx();
    case ($urandom_range(0, 2))
        0:       return LC_TX_ON;
        1:       return LC_TX_OFF;
        default: return lc_tx_e'(4'($urandom));    // Mostly non-ON garbage
    endcase
endfunction

function automatic logic [31:0] rand_sparse();
    return $urandom & $urandom & $urandom & $urandom;
endfunction

// Request held for a number of edges and then dropped for one
task automatic hold_request(input int cycles, input logic mask_full);
    zeroize_req = 1'b1;
    for (int i = 1; i <= cycles; i++) begin
        @(posedge clk);
        #1;
        check_value("zeroize_cmd_o", 64'(zeroize_cmd), 64'(mask_full && i >= ZEROIZE_HOLD));
        #1;
    end
    zeroize_req = 1'b0;
    @(posedge clk);
    #1;
    check_value("zeroize_cmd_o", 64'(zeroize_cmd), 64'h0);
    #1;
endtask

// Compare process runs three edges after each stimulus change
initial begin : compare_outputs
    lcx_status_t exp_out;
    forever begin
        wait (check_req);
        repeat (3) @(posedge clk);
        #1;
        exp_out = expected_status();
        check_value("security_state_o", 64'(sec_state), 64'(exp_out.security_state));
        check_value("soc_dft_en_o", 64'(dft_en), 64'(exp_out.soc_dft_en));
        check_value("soc_hw_debug_en_o", 64'(hw_dbg_en), 64'(exp_out.soc_hw_debug_en));
        check_value("zeroize_cmd_o", 64'(zeroize_cmd), 64'(exp_out.zeroize_cmd));
        check_req = 1'b0;
    end
end

initial begin : stimulus
    logic [31:0] rdat;
    logic [7:0]  adr;
    void'($urandom(93));
    rst_n       = 1'b0;
    wb_req      = '0;
    otp_data    = '0;
    prog_req    = '0;
    dft_tx      = LC_TX_OFF;
    hw_tx       = LC_TX_OFF;
    dbg_manuf   = 1'b0;
    state_err   = 1'b0;
    zeroize_req = 1'b0;
    for (int i = 0; i < 9; i++) begin
        shadow[i] = 32'h0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    settle_and_check();

    // Reset values followed by byte-lane writes and unmapped space
    for (int i = 0; i < 10; i++) begin
        wb_read(8'(4 * i), rdat);
        check_value("wb_o.dat", 64'(rdat),
                    (i == 9) ? 64'({26'd0, ref_security(TR_RESET, 1'b0), 3'b000}) : 64'h0);
    end
    for (int n = 0; n < 20; n++) begin
        adr = 8'(4 * $urandom_range(0, 8));
        wb_write(adr, $urandom, 4'($urandom));
        wb_read(adr, rdat);
        check_value("wb_o.dat", 64'(rdat), 64'(shadow[int'(adr[7:2])]));
    end
    for (int n = 0; n < 6; n++) begin
        adr = 8'(4 * $urandom_range(10, 63));
        wb_write(adr, $urandom, 4'hF);
        wb_read(adr, rdat);
        check_value("wb_o.dat", 64'(rdat), 64'h0);
    end
    clear_cfg();

    // Every fuse code including the undefined ones
    for (int f = 0; f < 24; f++) begin
        otp_data.state = lc_state_e'(5'(f));
        otp_data.valid = 1'b1;
        settle_and_check();
        otp_data.valid = 1'b0;
        settle_and_check();
    end

    // Manufacturing and production unlock paths
    otp_data = '{valid: 1'b1, state: LC_DEV};
    settle_and_check();
    dbg_manuf = 1'b1;
    settle_and_check();
    dbg_manuf      = 1'b0;
    otp_data.valid = 1'b0;
    settle_and_check();
    otp_data = '{valid: 1'b1, state: LC_PROD};
    settle_and_check();
    wb_write(8'h00, 32'h0000_00F0, 4'hF);
    wb_write(8'h10, 32'h0000_000F, 4'hF);
    settle_and_check();                     // No overlap so still locked
    wb_write(8'h14, 32'h8000_0000, 4'hF);
    wb_write(8'h04, 32'h8000_0000, 4'hF);
    settle_and_check();
    otp_data.valid = 1'b0;
    clear_cfg();
    settle_and_check();

    // Escalation from each decoded state stays sticky until valid toggles
    for (int f = 0; f < 4; f++) begin
        for (int cause = 0; cause < 2; cause++) begin
            otp_data = '{valid: 1'b1, state: esc_fuses[f]};
            settle_and_check();
            if (esc_fuses[f] == LC_DEV && cause == 1) begin
                dbg_manuf = 1'b1;
                settle_and_check();
            end
            set_escalation(cause, 1'b1);
            settle_and_check();
            set_escalation(cause, 1'b0);
            settle_and_check();
            dbg_manuf      = 1'b0;
            otp_data.valid = 1'b0;
            settle_and_check();
            otp_data.valid = 1'b1;
            settle_and_check();
            otp_data.valid = 1'b0;
            settle_and_check();
        end
    end

    // Enables with random lc_tx words and sparse masks
    otp_data.state = LC_PROD;
    for (int n = 0; n < 16; n++) begin
        dft_tx = pick_tx();
        hw_tx  = pick_tx();
        wb_write(8'h00, rand_sparse(), 4'hF);
        wb_write(8'h04, rand_sparse(), 4'hF);
        wb_write(8'h08, rand_sparse(), 4'hF);
        wb_write(8'h0C, rand_sparse(), 4'hF);
        wb_write(8'h18, rand_sparse(), 4'hF);
        wb_write(8'h1C, rand_sparse(), 4'hF);
        otp_data.valid = ($urandom_range(0, 3) != 0);
        settle_and_check();
        wb_read(8'h24, rdat);
        check_value("wb_o.dat", 64'(rdat), 64'(expected_status()));
    end
    dft_tx         = LC_TX_OFF;
    hw_tx          = LC_TX_OFF;
    otp_data.valid = 1'b0;
    clear_cfg();

    // Zeroization hold timer
    wb_write(8'h20, 32'hFFFF_FFFF, 4'hF);
    hold_request(7, 1'b1);
    hold_request(ZEROIZE_HOLD - 1, 1'b1);   // Too short to fire
    wb_write(8'h20, 32'hFFFF_FFFF & ~(32'h1 << $urandom_range(0, 31)), 4'hF);
    hold_request(8, 1'b0);

    $display("Simulation completed successfully");
    $finish;
end

endmodule

// File: build.f
+incdir+tb
src/lcx_pkg.sv
src/lcx_wb_regs.sv
src/lcx_state_trans.sv
src/lcx_zeroize_timer.sv
src/lcx_top.sv
tb/lcx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lcx_tb -f build.f -o lcx_sim \
    && ./obj_dir/lcx_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "Simulation failed" sim.log 2>/dev/null && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
    || { echo "FAIL (no pass message in sim.log)"; exit 1; }
echo "PASS"
